//--- vlog.f
+incdir+hw
hw/pool_pkg.sv
hw/pool_ram.sv
hw/sipo_pack.sv
hw/pool_cfg_regs.sv
hw/pool_engine.sv
hw/pool_sparse.sv
hw/pool_top.sv
tb/tb_clk_gen.sv
tb/pool_chk.sv
tb/pool_tb.sv

//--- Makefile
SIM  = obj_dir/Vpool_tb
SRCS = $(wildcard hw/*.sv hw/*.svh tb/*.sv)

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module pool_tb -f vlog.f

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || (echo "No pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- tb/pool_tb.sv
`timescale 1ns/1ns
`include "pool_defs.svh"

module pool_tb
    import pool_pkg::*;
();

    localparam int NPOS         = `LENPSUM * `LENPSUM;
    localparam int NWIN         = 1 << `WIN_ADDRWIDTH;
    // Stride 2 patch: reads, combine and write per window, plus margin
    localparam int PATCH_CYCLES = (`LENPSUM / 2) * (`LENPSUM / 2) * (4 + 2) + 16;
    localparam int WATCHDOG_NS  = 30 * PATCH_CYCLES * 8;

    logic                           clk;
    logic                           rst_n;
    logic                           cfg_wr;
    logic [`FL_WIDTH-1:0]           cfg_fl;
    logic [`STRIDE_WIDTH-1:0]       cfg_stride;
    logic                           cfg_frame;
    logic                           pool_start;
    logic                           busy;
    logic                           psum_rd_en;
    logic [`PSUM_ADDRWIDTH-1:0]     psum_rd_addr;
    lane_psum_t                     psum_dat;
    logic                           ofm_wr;
    logic [`OFM_ADDRWIDTH-1:0]      ofm_addr;
    logic [`PORT_DATAWIDTH-1:0]     ofm_dat;
    logic                           flg_wr;
    logic [`FLG_ADDRWIDTH-1:0]      flg_addr;
    logic [`PORT_DATAWIDTH-1:0]     flg_dat;
    logic                           patch_done;

    // PE buffer and reference state
    logic [`PSUM_WIDTH-1:0]         psum_mem [NPOS][`NUMPEB];
    logic [`PSUM_ADDRWIDTH-1:0]     rd_addr_q;
    logic [7:0]                     frame_ref [NWIN][`NUMPEB];
    logic [7:0]                     delta_ref [NWIN][`NUMPEB];
    logic [31:0]                    data_acc;
    logic [31:0]                    flag_acc;
    int                             data_cnt;
    int                             flag_cnt;
    int                             ofm_next;
    int                             flg_next;
    logic [31:0]                    exp_ofm_dat [$];
    int                             exp_ofm_addr [$];
    logic [31:0]                    exp_flg_dat [$];
    int                             exp_flg_addr [$];
    int                             ofm_seen;
    int                             flg_seen;
    int                             flg_nz_seen;
    int                             n_checks;
    logic [31:0]                    rng;
    string                          test_name;

    tb_clk_gen #(.PERIOD(8)) clk_gen (.clk(clk));

    pool_top UUT (.*);

    bind pool_top pool_chk u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .ofm_wr       (ofm_wr),
        .ofm_addr     (ofm_addr),
        .psum_rd_en   (psum_rd_en),
        .psum_rd_addr (psum_rd_addr),
        .stride       (stride),
        .patch_done   (patch_done),
        .busy         (busy)
    );

    // ====================
    // Helpers
    // ====================
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            $display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            stop_run("Value mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] relu_cut(input logic [15:0] ps, input int fl);
        logic [15:0] sh;
        sh = ps >> fl;
        if (ps[15])
            relu_cut = 8'd0;               // Negative psum
        else
            relu_cut = {1'b0, sh[6:0]};
    endfunction

    task automatic fill_psums(input bit negative);
        for (int a = 0; a < NPOS; a++) begin
            for (int l = 0; l < `NUMPEB; l++) begin
                rng = xorshift(rng);
                psum_mem[a][l] = negative ? {1'b1, rng[14:0]} : rng[15:0];
            end
        end
    endtask

    task automatic push_byte(input logic [7:0] b);
        data_acc[8*data_cnt +: 8] = b;     // First byte lowest
        data_cnt++;
        if (data_cnt == 4) begin
            exp_ofm_dat.push_back(data_acc);
            exp_ofm_addr.push_back(ofm_next);
            ofm_next++;
            data_cnt = 0;
        end
    endtask

    task automatic push_flag(input logic [3:0] f);
        flag_acc[4*flag_cnt +: 4] = f;
        flag_cnt++;
        if (flag_cnt == 8) begin
            exp_flg_dat.push_back(flag_acc);
            exp_flg_addr.push_back(flg_next);
            flg_next++;
            flag_cnt = 0;
        end
    endtask

    // Expected words for one patch, window by window
    task automatic model_patch(input int fl, input int st, input bit frm);
        int         nside;
        int         w;
        int         addr;
        logic [7:0] q;
        logic [7:0] mx;
        logic [7:0] res;
        logic [7:0] d;
        logic [3:0] flag;
        nside = `LENPSUM / st;
        for (int wy = 0; wy < nside; wy++) begin
            for (int wx = 0; wx < nside; wx++) begin
                w = wy * nside + wx;
                flag = '0;
                for (int l = 0; l < `NUMPEB; l++) begin
                    mx = '0;
                    for (int ky = 0; ky < st; ky++) begin
                        for (int kx = 0; kx < st; kx++) begin
                            addr = (wy * st + ky) * `LENPSUM + wx * st + kx;
                            q = relu_cut(psum_mem[addr][l], fl);
                            if (q > mx)
                                mx = q;
                        end
                    end
                    res = (frm && frame_ref[w][l] > mx) ? frame_ref[w][l] : mx;
                    d = res - delta_ref[w][l];       // Mod 256
                    frame_ref[w][l] = res;
                    delta_ref[w][l] = res;
                    flag[l] = (d != 8'd0);
                    if (d != 8'd0)
                        push_byte(d);
                end
                push_flag(flag);
            end
        end
    endtask

    task automatic write_cfg(input int fl, input int st, input bit frm);
        @(negedge clk);
        cfg_wr     = 1'b1;
        cfg_fl     = fl;
        cfg_stride = st;
        cfg_frame  = frm;
        @(negedge clk);
        cfg_wr     = 1'b0;
    endtask

    task automatic start_patch();
        int n;
        @(negedge clk);
        pool_start = 1'b1;
        @(negedge clk);
        pool_start = 1'b0;
        n = 0;
        while (!busy) begin
            if (n == 4)
                stop_run("busy did not rise after pool_start");
            else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic drain_outputs();
        int n;
        n = 0;
        while ((exp_ofm_dat.size() != 0 || exp_flg_dat.size() != 0) && n < 4 * `NUMPEB) begin
            @(negedge clk);
            n++;
        end
        check_val("pending data words", 0, exp_ofm_dat.size());
        check_val("pending flag words", 0, exp_flg_dat.size());
        repeat (`NUMPEB + 2) @(negedge clk);     // Lane scan settles
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!patch_done) begin
            if (n == PATCH_CYCLES)
                stop_run("patch_done did not come after the start");
            else begin
                @(negedge clk);
                n++;
            end
        end
        drain_outputs();
    endtask

    task automatic run_patch();
        start_patch();
        wait_done();
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic test_reset_state();
        test_name = "reset_state";
        check_val("ofm_wr", 0, ofm_wr);
        check_val("flg_wr", 0, flg_wr);
        check_val("psum_rd_en", 0, psum_rd_en);
        check_val("busy", 0, busy);
        check_val("patch_done", 0, patch_done);
        check_val("ofm_addr", 0, ofm_addr);
        check_val("flg_addr", 0, flg_addr);
    endtask

    task automatic test_stride2_random();
        test_name = "stride2_random";
        write_cfg(3, 2, 1'b0);
        fill_psums(1'b0);
        model_patch(3, 2, 1'b0);
        run_patch();
    endtask

    task automatic test_relu_quant();
        int snap_ofm;
        int snap_nz;
        test_name = "relu_quant";
        write_cfg(15, 2, 1'b0);              // Clamps to FL_MAX
        fill_psums(1'b0);
        model_patch(`FL_MAX, 2, 1'b0);
        run_patch();
        fill_psums(1'b1);
        model_patch(`FL_MAX, 2, 1'b0);
        run_patch();
        snap_ofm = ofm_seen;
        snap_nz  = flg_nz_seen;
        fill_psums(1'b1);
        model_patch(`FL_MAX, 2, 1'b0);
        run_patch();
        check_val("data writes", 0, ofm_seen - snap_ofm);
        check_val("nonzero flag words", 0, flg_nz_seen - snap_nz);
    endtask

    task automatic test_frame_pool();
        test_name = "frame_pool";
        write_cfg(5, 2, 1'b1);
        for (int p = 0; p < 2; p++) begin
            fill_psums(1'b0);
            model_patch(5, 2, 1'b1);
            run_patch();
        end
    endtask

    task automatic test_delta_repeat();
        int snap_ofm;
        int snap_nz;
        test_name = "delta_repeat";
        write_cfg(4, 2, 1'b0);
        fill_psums(1'b0);
        model_patch(4, 2, 1'b0);
        run_patch();
        model_patch(4, 2, 1'b0);             // Same psums again
        snap_ofm = ofm_seen;
        snap_nz  = flg_nz_seen;
        start_patch();
        write_cfg(0, 3, 1'b1);               // Must be dropped while busy
        wait_done();
        check_val("data writes", 0, ofm_seen - snap_ofm);
        check_val("nonzero flag words", 0, flg_nz_seen - snap_nz);
    endtask

    task automatic test_stride3_flags();
        int snap_flg;
        test_name = "stride3_flags";
        write_cfg(2, 3, 1'b0);
        snap_flg = flg_seen;
        fill_psums(1'b0);
        model_patch(2, 3, 1'b0);
        run_patch();
        check_val("flag words after one patch", 0, flg_seen - snap_flg);
        fill_psums(1'b0);
        model_patch(2, 3, 1'b0);
        run_patch();
        check_val("flag words after two patches", 1, flg_seen - snap_flg);
    endtask

    // ====================
    // PE buffer, monitor, watchdog
    // ====================
    initial begin
        psum_dat  = '0;
        rd_addr_q = '0;
        forever begin
            @(negedge clk);
            for (int l = 0; l < `NUMPEB; l++)
                psum_dat[l] = psum_mem[rd_addr_q][l];   // Read from last cycle
            rd_addr_q = psum_rd_addr;
        end
    end

    always @(negedge clk) begin
        if (rst_n && ofm_wr) begin
            ofm_seen++;
            if (exp_ofm_dat.size() == 0)
                stop_run("Data word written with none expected");
            else begin
                check_val("ofm_dat", exp_ofm_dat.pop_front(), ofm_dat);
                check_val("ofm_addr", exp_ofm_addr.pop_front(), ofm_addr);
            end
        end
        if (rst_n && flg_wr) begin
            flg_seen++;
            if (flg_dat != '0)
                flg_nz_seen++;
            if (exp_flg_dat.size() == 0)
                stop_run("Flag word written with none expected");
            else begin
                check_val("flg_dat", exp_flg_dat.pop_front(), flg_dat);
                check_val("flg_addr", exp_flg_addr.pop_front(), flg_addr);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run("Watchdog timeout, the tests did not finish in time");
    end

    initial begin
        rst_n      = 1'b0;
        cfg_wr     = 1'b0;
        cfg_fl     = '0;
        cfg_stride = 2'd2;
        cfg_frame  = 1'b0;
        pool_start = 1'b0;
        rng        = 32'h4993_3d3a;
        data_acc   = '0;
        flag_acc   = '0;
        data_cnt   = 0;
        flag_cnt   = 0;
        ofm_next   = 0;
        flg_next   = 0;
        n_checks   = 0;
        test_name  = "init";
        for (int a = 0; a < NPOS; a++) begin
            for (int l = 0; l < `NUMPEB; l++)
                psum_mem[a][l] = '0;
        end
        for (int w = 0; w < NWIN; w++) begin
            for (int l = 0; l < `NUMPEB; l++) begin
                frame_ref[w][l] = '0;
                delta_ref[w][l] = '0;
            end
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_stride2_random();
        test_relu_quant();
        test_frame_pool();
        test_delta_repeat();
        test_stride3_flags();
        if (n_checks == 0) begin
            stop_run("No checks were run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- tb/pool_chk.sv
`timescale 1ns/1ns
`include "pool_defs.svh"

module pool_chk (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ofm_wr,
    input  logic [`OFM_ADDRWIDTH-1:0]   ofm_addr,
    input  logic                        psum_rd_en,
    input  logic [`PSUM_ADDRWIDTH-1:0]  psum_rd_addr,
    input  logic [`STRIDE_WIDTH-1:0]    stride,
    input  logic                        patch_done,
    input  logic                        busy
);

    int span;    // Tile rows and columns that full windows cover

    assign span = (stride == 2'd3) ? (`LENPSUM / 3) * 3 : (`LENPSUM / 2) * 2;

    // ====================
    // Output stream
    // ====================
    a_ofm_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr |=> (ofm_addr == $past(ofm_addr) + 1'b1))
        else $error("ofm_addr did not advance by one after a data write");

    // Reads stay inside the part of the tile that windows cover
    a_psum_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        psum_rd_en |-> (int'(psum_rd_addr) / `LENPSUM < span)
                    && (int'(psum_rd_addr) % `LENPSUM < span))
        else $error("psum read address outside the windowed part of the tile");

    a_done_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        patch_done |-> busy)
        else $error("patch_done seen while busy was low");

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;   // Half period per edge

endmodule

//--- hw/pool_top.sv
`timescale 1ns/1ns
`include "pool_defs.svh"

module pool_top
    import pool_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cfg_wr,
    input  logic [`FL_WIDTH-1:0]        cfg_fl,
    input  logic [`STRIDE_WIDTH-1:0]    cfg_stride,
    input  logic                        cfg_frame,
    input  logic                        pool_start,
    output logic                        busy,
    output logic                        psum_rd_en,
    output logic [`PSUM_ADDRWIDTH-1:0]  psum_rd_addr,
    input  lane_psum_t                  psum_dat,
    output logic                        ofm_wr,
    output logic [`OFM_ADDRWIDTH-1:0]   ofm_addr,
    output logic [`PORT_DATAWIDTH-1:0]  ofm_dat,
    output logic                        flg_wr,
    output logic [`FLG_ADDRWIDTH-1:0]   flg_addr,
    output logic [`PORT_DATAWIDTH-1:0]  flg_dat,
    output logic                        patch_done
);

    logic [`FL_WIDTH-1:0]       fl_eff;
    logic [`STRIDE_WIDTH-1:0]   stride;
    logic                       frame_en;
    logic                       patch_go;
    logic                       win_valid;
    lane_bytes_t                win_delta;

    pool_cfg_regs u_cfg (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_fl     (cfg_fl),
        .cfg_stride (cfg_stride),
        .cfg_frame  (cfg_frame),
        .pool_start (pool_start),
        .patch_done (patch_done),
        .fl_eff     (fl_eff),
        .stride     (stride),
        .frame_en   (frame_en),
        .patch_go   (patch_go),
        .busy       (busy)
    );

    pool_engine u_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .patch_go     (patch_go),
        .fl_eff       (fl_eff),
        .stride       (stride),
        .frame_en     (frame_en),
        .psum_rd_en   (psum_rd_en),
        .psum_rd_addr (psum_rd_addr),
        .psum_dat     (psum_dat),
        .win_valid    (win_valid),
        .win_delta    (win_delta),
        .patch_done   (patch_done)
    );

    pool_sparse u_sparse (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .win_delta (win_delta),
        .ofm_wr    (ofm_wr),
        .ofm_addr  (ofm_addr),
        .ofm_dat   (ofm_dat),
        .flg_wr    (flg_wr),
        .flg_addr  (flg_addr),
        .flg_dat   (flg_dat)
    );

endmodule

//--- hw/pool_sparse.sv
`timescale 1ns/1ns
`include "pool_defs.svh"

module pool_sparse
    import pool_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        win_valid,
    input  lane_bytes_t                 win_delta,
    output logic                        ofm_wr,
    output logic [`OFM_ADDRWIDTH-1:0]   ofm_addr,
    output logic [`PORT_DATAWIDTH-1:0]  ofm_dat,
    output logic                        flg_wr,
    output logic [`FLG_ADDRWIDTH-1:0]   flg_addr,
    output logic [`PORT_DATAWIDTH-1:0]  flg_dat
);

    localparam int LW = $clog2(`NUMPEB);

    lane_bytes_t    scan_q;
    lane_flag_t     flag;
    logic [LW-1:0]  lane;
    logic           scan_act;
    logic           byte_push;

    always_comb begin
        for (int i = 0; i < `NUMPEB; i++)
            flag[i] = |win_delta[i];
    end

    always_ff @(posedge clk) begin
        if (win_valid)
            scan_q <= win_delta;
    end

    // ====================
    // Lane scan, one per cycle
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_act <= 1'b0;
            lane     <= '0;
        end else if (win_valid) begin
            scan_act <= 1'b1;
            lane     <= '0;
        end else if (scan_act) begin
            lane <= lane + 1'b1;
            if (lane == LW'(`NUMPEB - 1))
                scan_act <= 1'b0;
        end
    end

    assign byte_push = scan_act && (scan_q[lane] != '0);   // Zeros dropped

    sipo_pack #(.payload_t(logic [`DATA_WIDTH-1:0])) ofm_pack (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (byte_push),
        .din        (scan_q[lane]),
        .dout       (ofm_dat),
        .dout_valid (ofm_wr)
    );

    sipo_pack #(.payload_t(lane_flag_t)) flg_pack (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (win_valid),
        .din        (flag),
        .dout       (flg_dat),
        .dout_valid (flg_wr)
    );

    // Write addresses run on across patches
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_addr <= '0;
            flg_addr <= '0;
        end else begin
            if (ofm_wr)
                ofm_addr <= ofm_addr + 1'b1;
            if (flg_wr)
                flg_addr <= flg_addr + 1'b1;
        end
    end

endmodule

//--- hw/pool_engine.sv
`timescale 1ns/1ns
`include "pool_defs.svh"

module pool_engine
    import pool_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        patch_go,
    input  logic [`FL_WIDTH-1:0]        fl_eff,
    input  logic [`STRIDE_WIDTH-1:0]    stride,
    input  logic                        frame_en,
    output logic                        psum_rd_en,
    output logic [`PSUM_ADDRWIDTH-1:0]  psum_rd_addr,
    input  lane_psum_t                  psum_dat,
    output logic                        win_valid,
    output lane_bytes_t                 win_delta,
    output logic                        patch_done
);

    localparam int AW = `PSUM_ADDRWIDTH;
    localparam int WW = `WIN_ADDRWIDTH;

    typedef enum logic [1:0] {st_idle, st_read, st_combine, st_write} state_t;

    state_t         state;
    state_t         state_nxt;
    logic [1:0]     kx;
    logic [1:0]     ky;
    logic [1:0]     wx;
    logic [1:0]     wy;
    logic [1:0]     kmax;
    logic [1:0]     wmax;
    logic [WW-1:0]  win_cnt;
    logic [AW-1:0]  row;
    logic [AW-1:0]  col;
    logic           tap_last;
    logic           win_last;
    logic           rd_en_d;
    logic           ram_rd;
    logic           ram_wr;
    lane_bytes_t    q_val;
    lane_bytes_t    max_q;
    lane_bytes_t    frm_rd;
    lane_bytes_t    dlt_rd;
    lane_bytes_t    res;
    lane_bytes_t    delta;

    // ====================
    // Window walk
    // ====================
    assign kmax     = stride - 2'd1;
    assign wmax     = (stride == 2'd3) ? 2'(`LENPSUM / 3 - 1) : 2'(`LENPSUM / 2 - 1);
    assign tap_last = (kx == kmax) && (ky == kmax);
    assign win_last = (wx == wmax) && (wy == wmax);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (patch_go) state_nxt = st_read;
            st_read:    if (tap_last) state_nxt = st_combine;
            st_combine: state_nxt = st_write;     // Last psum lands, RAMs read
            st_write:   state_nxt = win_last ? st_idle : st_read;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kx      <= '0;
            ky      <= '0;
            wx      <= '0;
            wy      <= '0;
            win_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    kx      <= '0;
                    ky      <= '0;
                    wx      <= '0;
                    wy      <= '0;
                    win_cnt <= '0;
                end
                st_read: begin
                    if (kx == kmax) begin
                        kx <= '0;
                        ky <= (ky == kmax) ? 2'd0 : ky + 2'd1;
                    end else begin
                        kx <= kx + 2'd1;       // kx fastest
                    end
                end
                st_write: begin
                    win_cnt <= win_last ? '0 : win_cnt + 1'b1;
                    if (wx == wmax) begin
                        wx <= '0;
                        wy <= (wy == wmax) ? 2'd0 : wy + 2'd1;
                    end else begin
                        wx <= wx + 2'd1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Psum address within the tile
    assign row          = AW'(wy) * AW'(stride) + AW'(ky);
    assign col          = AW'(wx) * AW'(stride) + AW'(kx);
    assign psum_rd_addr = AW'(row * `LENPSUM + col);
    assign psum_rd_en   = (state == st_read);

    // ====================
    // ReLU, cut and max
    // ====================
    always_comb begin
        for (int i = 0; i < `NUMPEB; i++) begin
            if (psum_dat[i][`PSUM_WIDTH-1])
                q_val[i] = '0;
            else
                q_val[i] = {1'b0, psum_dat[i][fl_eff +: `DATA_WIDTH-1]};
        end
    end

    // Values are never negative, so zero starts each window
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUMPEB; i++) begin
            if (state == st_idle || state == st_write)
                max_q[i] <= '0;
            else if (rd_en_d && q_val[i] > max_q[i])
                max_q[i] <= q_val[i];
        end
    end

    // Frame merge, then delta against last patch
    always_comb begin
        for (int i = 0; i < `NUMPEB; i++) begin
            res[i]   = (frame_en && frm_rd[i] > max_q[i]) ? frm_rd[i] : max_q[i];
            delta[i] = res[i] - dlt_rd[i];      // Wraps mod 256
        end
    end

    assign ram_rd = (state == st_combine);
    assign ram_wr = (state == st_write);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en_d    <= 1'b0;
            win_valid  <= 1'b0;
            patch_done <= 1'b0;
        end else begin
            rd_en_d    <= psum_rd_en;              // Matches read latency
            win_valid  <= ram_wr;
            patch_done <= ram_wr && win_last;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_wr)
            win_delta <= delta;
    end

    pool_ram #(.DEPTH(1 << WW)) frame_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_en   (ram_rd),
        .rd_addr (win_cnt),
        .wr_en   (ram_wr),
        .wr_addr (win_cnt),
        .wr_dat  (res),
        .rd_dat  (frm_rd)
    );

    pool_ram #(.DEPTH(1 << WW)) delta_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_en   (ram_rd),
        .rd_addr (win_cnt),
        .wr_en   (ram_wr),
        .wr_addr (win_cnt),
        .wr_dat  (res),
        .rd_dat  (dlt_rd)
    );

endmodule

//--- hw/pool_cfg_regs.sv
`timescale 1ns/1ns
`include "pool_defs.svh"

module pool_cfg_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cfg_wr,
    input  logic [`FL_WIDTH-1:0]        cfg_fl,
    input  logic [`STRIDE_WIDTH-1:0]    cfg_stride,
    input  logic                        cfg_frame,
    input  logic                        pool_start,
    input  logic                        patch_done,
    output logic [`FL_WIDTH-1:0]        fl_eff,
    output logic [`STRIDE_WIDTH-1:0]    stride,
    output logic                        frame_en,
    output logic                        patch_go,
    output logic                        busy
);

    localparam logic [`FL_WIDTH-1:0] FL_CLAMP = `FL_MAX;

    logic start_ok;

    assign start_ok = pool_start && !busy;     // Starts while busy are dropped

    // Config is frozen for the whole patch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fl_eff   <= '0;
            stride   <= 2'd2;
            frame_en <= 1'b0;
        end else if (cfg_wr && !busy) begin
            fl_eff   <= (cfg_fl > FL_CLAMP) ? FL_CLAMP : cfg_fl;
            stride   <= (cfg_stride == 2'd3) ? 2'd3 : 2'd2;  // Only 2 and 3 exist
            frame_en <= cfg_frame;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            patch_go <= 1'b0;
        end else begin
            patch_go <= start_ok;
            if (start_ok)
                busy <= 1'b1;
            else if (patch_done)
                busy <= 1'b0;
        end
    end

endmodule

//--- hw/sipo_pack.sv
`timescale 1ns/1ns
`include "pool_defs.svh"

module sipo_pack #(
    parameter type payload_t = logic [7:0]
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  payload_t                    din,
    output logic [`PORT_DATAWIDTH-1:0]  dout,
    output logic                        dout_valid
);

    localparam int PW    = $bits(payload_t);
    localparam int NSLOT = `PORT_DATAWIDTH / PW;
    localparam int CW    = $clog2(NSLOT);

    logic [`PORT_DATAWIDTH-1:0] shreg;
    logic [CW-1:0]              slot;
    logic                       slot_last;

    assign slot_last = (slot == CW'(NSLOT - 1));

    // New payload enters at the top and moves down, first one ends lowest
    always_ff @(posedge clk) begin
        if (push)
            shreg <= {din, shreg[`PORT_DATAWIDTH-1:PW]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot       <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= push && slot_last;    // Word stays valid for one cycle
            if (push)
                slot <= slot_last ? '0 : slot + 1'b1;
        end
    end

    assign dout = shreg;

endmodule

//--- hw/pool_ram.sv
`timescale 1ns/1ns

module pool_ram
    import pool_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  lane_bytes_t              wr_dat,
    output lane_bytes_t              rd_dat
);

    lane_bytes_t mem [DEPTH];

    // Previous patch starts from all zeros
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < DEPTH; k++)
                mem[k] <= '{default: '0};
            rd_dat <= '{default: '0};
        end else begin
            if (wr_en)
                mem[wr_addr] <= wr_dat;
            if (rd_en)
                rd_dat <= mem[rd_addr];   // One cycle read
        end
    end

endmodule

//--- hw/pool_pkg.sv
`include "pool_defs.svh"

package pool_pkg;

    // One pooled byte per lane
    typedef logic [`DATA_WIDTH-1:0] lane_bytes_t [`NUMPEB];

    // Raw psums as they leave the PE buffer, lane 0 in the low bits
    typedef logic [`NUMPEB-1:0][`PSUM_WIDTH-1:0] lane_psum_t;

    // Bit i set when lane i holds a nonzero delta
    typedef logic [`NUMPEB-1:0] lane_flag_t;

endpackage

//--- hw/pool_defs.svh
`ifndef POOL_DEFS_SVH
`define POOL_DEFS_SVH

// ====================
// Array and tile sizes
// ====================
`define NUMPEB          4       // Lanes from the PE array
`define PSUM_WIDTH      16
`define DATA_WIDTH      8       // Pooled value
`define LENPSUM         8       // Tile side
`define PSUM_ADDRWIDTH  6

// Output buffer side
`define PORT_DATAWIDTH  32
`define OFM_ADDRWIDTH   10
`define FLG_ADDRWIDTH   10

// Window index and config fields
`define WIN_ADDRWIDTH   4
`define FL_MAX          9       // Largest fractional length
`define FL_WIDTH        4
`define STRIDE_WIDTH    2

`endif
